/* hdl/mem_bus_pkg.sv */
// Core-facing types for the fetch, LSU and MMU ports
// Addresses are byte addresses; the memory only uses word-aligned accesses
package mem_bus_pkg;

    typedef logic [31:0] addr_t;  // Byte address
    typedef logic [31:0] data_t;  // One data word
    typedef logic [3:0]  strb_t;  // One strobe per byte lane

    // Instruction fetch request
    typedef struct packed {
        logic  req;   // Held until ack
        logic  kill;  // One-cycle pulse, req drops with it
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  ack;     // One-cycle pulse
        data_t r_data;  // Valid with ack only
    } fetch_rsp_t;

    // Load/store bus
    typedef struct packed {
        logic  req;
        logic  w_en;    // 1 = store
        addr_t addr;
        data_t w_data;
        strb_t strb;    // Byte enables for stores
    } dbus_req_t;

    typedef struct packed {
        logic  ack;
        data_t r_data;  // Load data, ignore on stores
    } dbus_rsp_t;

    // MMU page-table walker, reads only
    typedef struct packed {
        logic  r_req;
        logic  flush;   // Kills the pending walk read
        addr_t paddr;
    } mmu_req_t;

    typedef struct packed {
        logic  r_valid;  // One-cycle pulse
        data_t r_data;
    } mmu_rsp_t;

endpackage

/* hdl/mem_port_pkg.sv */
// Internal channels between the arbiters and the main memory
// Field layout follows the LSU request so a data grant needs no repacking
package mem_port_pkg;

    // Data port, LSU or MMU after the first arbiter
    typedef struct packed {
        logic               req;
        logic               w_en;
        mem_bus_pkg::addr_t addr;
        mem_bus_pkg::data_t w_data;
        mem_bus_pkg::strb_t strb;   // Zero for MMU reads
    } data_req_t;

    typedef struct packed {
        logic               ack;
        mem_bus_pkg::data_t r_data;
    } data_rsp_t;

    // Main memory channel, registered in the memory arbiter
    typedef struct packed {
        logic               req;
        logic               w_en;
        mem_bus_pkg::addr_t addr;
        mem_bus_pkg::data_t w_data;
        mem_bus_pkg::strb_t strb;
    } mem_req_t;

    typedef struct packed {
        logic               ack;     // Exactly MEM_LATENCY cycles after accept
        mem_bus_pkg::data_t r_data;
    } mem_rsp_t;

endpackage

/* hdl/dport_arbiter.sv */
// LSU/MMU arbiter for the data port with fixed LSU priority
// One registered grant stage, so a data access costs one extra cycle
// MMU flush only acts while the MMU holds the grant
module dport_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_bus_pkg::dbus_req_t  dbus_req_i,
    output mem_bus_pkg::dbus_rsp_t  dbus_rsp_o,
    input  mem_bus_pkg::mmu_req_t   mmu_req_i,
    output mem_bus_pkg::mmu_rsp_t   mmu_rsp_o,
    output mem_port_pkg::data_req_t data_req_o,
    input  mem_port_pkg::data_rsp_t data_rsp_i,
    output logic                    data_kill_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LSU,
        ST_MMU
    } dport_state_e;

    dport_state_e state_q, state_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Grant selection
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (dbus_req_i.req) begin
                    state_d = ST_LSU;  // LSU wins ties
                end else if (mmu_req_i.r_req && !mmu_req_i.flush) begin
                    state_d = ST_MMU;
                end
            end
            ST_LSU: begin
                if (data_rsp_i.ack) begin
                    state_d = ST_IDLE;
                end
            end
            ST_MMU: begin
                // Flush beats a same-cycle ack that the mem arbiter drops
                if (mmu_req_i.flush || data_rsp_i.ack) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // Request forwarding and ack steering from the registered grant
    always_comb begin
        data_req_o        = '0;
        data_kill_o       = 1'b0;
        dbus_rsp_o.ack    = 1'b0;
        dbus_rsp_o.r_data = data_rsp_i.r_data;  // Qualified by ack
        mmu_rsp_o.r_valid = 1'b0;
        mmu_rsp_o.r_data  = data_rsp_i.r_data;
        case (state_q)
            ST_LSU: begin
                data_req_o.req    = dbus_req_i.req;
                data_req_o.w_en   = dbus_req_i.w_en;
                data_req_o.addr   = dbus_req_i.addr;
                data_req_o.w_data = dbus_req_i.w_data;
                data_req_o.strb   = dbus_req_i.strb;
                dbus_rsp_o.ack    = data_rsp_i.ack;
            end
            ST_MMU: begin
                if (mmu_req_i.flush) begin
                    data_kill_o = 1'b1;  // Request already dropped here
                end else begin
                    // Walk read with no write data and no strobes
                    data_req_o.req    = mmu_req_i.r_req;
                    data_req_o.addr   = mmu_req_i.paddr;
                    mmu_rsp_o.r_valid = data_rsp_i.ack;
                end
            end
            default: data_req_o = '0;
        endcase
    end

    // Only one requester ever sees the shared ack
    a_single_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_rsp_o.ack && mmu_rsp_o.r_valid));

    // Kill ends a walk read that the MMU held up to the flush edge
    a_kill_from_mmu: assert property (@(posedge clk) disable iff (!rst_n)
        data_kill_o |-> $past(mmu_req_i.r_req) && !mmu_req_i.r_req);

endmodule

/* hdl/mem_arbiter.sv */
// Data/fetch arbiter for main memory, data port has fixed priority
// Memory request is registered and held until the memory ack
// A killed access still waits for its ack, which is then dropped
module mem_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_port_pkg::data_req_t data_req_i,
    output mem_port_pkg::data_rsp_t data_rsp_o,
    input  logic                    data_kill_i,
    input  mem_bus_pkg::fetch_req_t fetch_req_i,
    output mem_bus_pkg::fetch_rsp_t fetch_rsp_o,
    output mem_port_pkg::mem_req_t  mem_req_o,
    input  mem_port_pkg::mem_rsp_t  mem_rsp_i
);

    import mem_port_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DATA,
        ST_FETCH,
        ST_DKILL,  // Draining a killed data access
        ST_FKILL   // Draining a killed fetch
    } marb_state_e;

    marb_state_e state_q, state_d;
    mem_req_t    mem_req_q, mem_req_d;
    logic        mem_ack;

    assign mem_ack   = mem_rsp_i.ack;
    assign mem_req_o = mem_req_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            mem_req_q <= '0;
        end else begin
            state_q   <= state_d;
            mem_req_q <= mem_req_d;
        end
    end

    always_comb begin
        state_d            = state_q;
        mem_req_d          = mem_req_q;          // Held while pending
        data_rsp_o.ack     = 1'b0;
        data_rsp_o.r_data  = mem_rsp_i.r_data;
        fetch_rsp_o.ack    = 1'b0;
        fetch_rsp_o.r_data = mem_rsp_i.r_data;
        case (state_q)
            ST_IDLE: begin
                mem_req_d = '0;
                if (data_req_i.req) begin
                    mem_req_d.req    = 1'b1;
                    mem_req_d.w_en   = data_req_i.w_en;
                    mem_req_d.addr   = data_req_i.addr;
                    mem_req_d.w_data = data_req_i.w_data;
                    mem_req_d.strb   = data_req_i.strb;
                    state_d          = ST_DATA;
                end else if (fetch_req_i.req) begin
                    mem_req_d.req  = 1'b1;  // Fetch is always a read
                    mem_req_d.addr = fetch_req_i.addr;
                    state_d        = ST_FETCH;
                end
            end
            ST_DATA: begin
                if (data_kill_i) begin
                    // Ack in the kill cycle is simply dropped
                    state_d = mem_ack ? ST_IDLE : ST_DKILL;
                end else if (mem_ack) begin
                    data_rsp_o.ack = 1'b1;
                    state_d        = ST_IDLE;
                end
            end
            ST_FETCH: begin
                if (fetch_req_i.kill) begin
                    state_d = mem_ack ? ST_IDLE : ST_FKILL;
                end else if (mem_ack) begin
                    fetch_rsp_o.ack = 1'b1;
                    state_d         = ST_IDLE;
                end
            end
            ST_DKILL, ST_FKILL: begin
                if (mem_ack) begin
                    state_d = ST_IDLE;  // Swallow the orphan ack
                end
            end
            default: state_d = ST_IDLE;
        endcase

        // Every ack ends the access, so memory sees no req in the idle cycle
        if (mem_ack) begin
            mem_req_d = '0;
        end
    end

    // Memory channel is frozen from grant until its ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_o.req && !mem_rsp_i.ack |=> $stable(mem_req_o));

    // One memory ack reaches at most one requester
    a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_rsp_o.ack && fetch_rsp_o.ack));

endmodule

/* hdl/main_mem.sv */
// Word memory with fixed latency, word index taken above the byte offset
// Upper address bits alias; contents are undefined until written
// Requests are ignored while busy and in the ack cycle
module main_mem #(
    parameter int MEM_LATENCY = 3,  // At least 1
    parameter int MEM_AW      = 8   // log2 of depth in words
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_port_pkg::mem_req_t mem_req_i,
    output mem_port_pkg::mem_rsp_t mem_rsp_o
);

    import mem_bus_pkg::*;

    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    typedef logic [MEM_AW-1:0] word_idx_t;
    typedef logic [CNT_W-1:0]  lat_cnt_t;

    data_t     mem_q [2**MEM_AW];
    word_idx_t idx_q;
    data_t     w_data_q;
    strb_t     strb_q;
    logic      w_en_q;
    data_t     r_data_q;
    logic      busy_q;
    logic      ack_q;
    lat_cnt_t  cnt_q;
    logic      accept;
    logic      done;

    assign accept = mem_req_i.req && !busy_q && !ack_q;
    assign done   = busy_q && (cnt_q == lat_cnt_t'(MEM_LATENCY - 1));  // Last wait cycle

    assign mem_rsp_o.ack    = ack_q;
    assign mem_rsp_o.r_data = r_data_q;

    // Latency timer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
            cnt_q  <= '0;
        end else begin
            ack_q <= done;
            if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (done) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + lat_cnt_t'(1);
            end
        end
    end

    // Request latch, requester may change fields after accept
    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q    <= mem_req_i.addr[MEM_AW+1:2];
            w_en_q   <= mem_req_i.w_en;
            w_data_q <= mem_req_i.w_data;
            strb_q   <= mem_req_i.strb;
        end
    end

    // Array access at the ack edge, reads return the old word
    always_ff @(posedge clk) begin
        if (done) begin
            r_data_q <= mem_q[idx_q];
            if (w_en_q) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (strb_q[b]) begin
                        mem_q[idx_q][8*b +: 8] <= w_data_q[8*b +: 8];
                    end
                end
            end
        end
    end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_o.ack |=> !mem_rsp_o.ack);

    // Fixed latency from accept to ack
    a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##(MEM_LATENCY + 1) mem_rsp_o.ack);

endmodule

/* hdl/mem_subsys_top.sv */
// Memory subsystem: LSU/MMU data port and fetch port share one main memory
// Fetch latency idle is MEM_LATENCY+1, data port latency idle is MEM_LATENCY+2
module mem_subsys_top #(
    parameter int MEM_LATENCY = 3,  // Memory ack delay, at least 1
    parameter int MEM_AW      = 8   // Memory depth, log2 words
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_bus_pkg::fetch_req_t fetch_req_i,
    output mem_bus_pkg::fetch_rsp_t fetch_rsp_o,
    input  mem_bus_pkg::dbus_req_t  dbus_req_i,
    output mem_bus_pkg::dbus_rsp_t  dbus_rsp_o,
    input  mem_bus_pkg::mmu_req_t   mmu_req_i,
    output mem_bus_pkg::mmu_rsp_t   mmu_rsp_o
);

    import mem_port_pkg::*;

    data_req_t data_req;   // Granted LSU or MMU access
    data_rsp_t data_rsp;
    logic      data_kill;  // MMU flush of a granted walk read
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    // LSU over MMU
    dport_arbiter u_dport_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus_req_i  (dbus_req_i),
        .dbus_rsp_o  (dbus_rsp_o),
        .mmu_req_i   (mmu_req_i),
        .mmu_rsp_o   (mmu_rsp_o),
        .data_req_o  (data_req),
        .data_rsp_i  (data_rsp),
        .data_kill_o (data_kill)
    );

    // Data port over fetch
    mem_arbiter u_mem_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .data_kill_i (data_kill),
        .fetch_req_i (fetch_req_i),
        .fetch_rsp_o (fetch_rsp_o),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    main_mem #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_AW      (MEM_AW)
    ) u_main_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

/* verification/mem_subsys_tb.sv */
// Testbench for mem_subsys_top, MEM_LATENCY 3, MEM_AW 8
// Reads only target words written earlier, since memory starts undefined
// Concurrent assertions check data, stray acks and grant order
module mem_subsys_tb;

    import mem_bus_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int MEM_LATENCY  = 3;
    localparam int MEM_AW       = 8;
    localparam int N_WORDS      = 8;                       // Words touched by the tests
    localparam int NUM_ACCESSES = 5 * N_WORDS + 12;        // All accesses of all tests
    localparam int ACK_LIMIT    = 4 * (MEM_LATENCY + 4);   // Per-access wait, covers contention
    localparam int PORT_LSU     = 0;
    localparam int PORT_FETCH   = 1;
    localparam int PORT_MMU     = 2;

    logic       clk;
    logic       rst_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    dbus_req_t  dbus_req;
    dbus_rsp_t  dbus_rsp;
    mmu_req_t   mmu_req;
    mmu_rsp_t   mmu_rsp;

    data_t       shadow [2**MEM_AW];  // Reference memory, word indexed
    addr_t       word_addr [N_WORDS];
    logic [31:0] rng_q;
    data_t       exp_dbus_data;
    logic        exp_dbus_w_en;
    data_t       exp_fetch_data;
    data_t       exp_mmu_data;
    logic        dbus_open;           // An LSU access is pending
    logic        fetch_open;
    logic        mmu_open;
    logic        prio_fetch;          // Data-before-fetch order checked
    logic        prio_mmu;            // LSU-before-MMU order checked
    int          err_cnt;
    int          tests_passed;
    int          tests_failed;

    mem_subsys_top #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_AW      (MEM_AW)
    ) u_mem_subsys_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .dbus_req_i  (dbus_req),
        .dbus_rsp_o  (dbus_rsp),
        .mmu_req_i   (mmu_req),
        .mmu_rsp_o   (mmu_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Read data against the shadow word
    a_dbus_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp.ack && !exp_dbus_w_en |-> dbus_rsp.r_data == exp_dbus_data)
        else begin
            $display("mismatch time=%0t signal=dbus_rsp_o.r_data expected=%h actual=%h",
                     $time, $sampled(exp_dbus_data), $sampled(dbus_rsp.r_data));
            err_cnt++;
        end
    a_fetch_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.ack |-> fetch_rsp.r_data == exp_fetch_data)
        else begin
            $display("mismatch time=%0t signal=fetch_rsp_o.r_data expected=%h actual=%h",
                     $time, $sampled(exp_fetch_data), $sampled(fetch_rsp.r_data));
            err_cnt++;
        end
    a_mmu_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        mmu_rsp.r_valid |-> mmu_rsp.r_data == exp_mmu_data)
        else begin
            $display("mismatch time=%0t signal=mmu_rsp_o.r_data expected=%h actual=%h",
                     $time, $sampled(exp_mmu_data), $sampled(mmu_rsp.r_data));
            err_cnt++;
        end

    // No ack without a live request, so killed and flushed accesses stay silent
    a_dbus_open: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_rsp.ack |-> dbus_open)
        else begin
            $display("error time=%0t: LSU ack with no LSU access pending", $time);
            err_cnt++;
        end
    a_fetch_open: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.ack |-> fetch_open)
        else begin
            $display("error time=%0t: fetch ack with no live fetch", $time);
            err_cnt++;
        end
    a_mmu_open: assert property (@(posedge clk) disable iff (!rst_n)
        mmu_rsp.r_valid |-> mmu_open)
        else begin
            $display("error time=%0t: MMU r_valid with no live walk read", $time);
            err_cnt++;
        end

    // Winner order under contention
    a_data_first: assert property (@(posedge clk) disable iff (!rst_n)
        prio_fetch && fetch_rsp.ack |-> !dbus_open)
        else begin
            $display("error time=%0t: fetch acked before the pending LSU read", $time);
            err_cnt++;
        end
    a_lsu_first: assert property (@(posedge clk) disable iff (!rst_n)
        prio_mmu && mmu_rsp.r_valid |-> !dbus_open)
        else begin
            $display("error time=%0t: MMU read served before the pending LSU read", $time);
            err_cnt++;
        end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_q = xorshift(rng_q);
        return rng_q;
    endfunction

    // Strobed bytes replace, the others keep the old word
    function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic port_ack(input int port);
        case (port)
            PORT_LSU:   return dbus_rsp.ack;
            PORT_FETCH: return fetch_rsp.ack;
            default:    return mmu_rsp.r_valid;
        endcase
    endfunction

    // Ack sampled mid-cycle, returns at the edge where it is taken
    task automatic wait_ack(input int port, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < ACK_LIMIT) begin
            @(negedge clk);
            seen = port_ack(port);
            n++;
        end
        @(posedge clk);
        if (!seen) begin
            $display("error time=%0t: port %0d gave no ack within %0d cycles", $time, port, n);
            err_cnt++;
        end
    endtask

    task automatic lsu_access(input logic w_en, input addr_t addr, input data_t wd,
                              input strb_t strb);
        int   idx;
        logic seen;
        idx = addr[MEM_AW+1:2];  // Upper bits alias
        @(posedge clk);
        dbus_req      <= '{req: 1'b1, w_en: w_en, addr: addr, w_data: wd, strb: strb};
        exp_dbus_w_en <= w_en;
        exp_dbus_data <= shadow[idx];
        dbus_open     <= 1'b1;
        wait_ack(PORT_LSU, seen);
        if (seen && w_en) shadow[idx] = merge_bytes(shadow[idx], wd, strb);
        dbus_req.req <= 1'b0;
        dbus_open    <= 1'b0;
    endtask

    // lag delays the raise so the fetch meets a granted data port
    task automatic fetch_access(input addr_t addr, input logic kill, input int lag);
        logic seen;
        repeat (lag) @(posedge clk);
        @(posedge clk);
        fetch_req      <= '{req: 1'b1, kill: 1'b0, addr: addr};
        exp_fetch_data <= shadow[addr[MEM_AW+1:2]];
        fetch_open     <= 1'b1;
        if (kill) begin
            repeat (2) @(posedge clk);  // Fetch is granted by now, ack still ahead
            fetch_req  <= '{req: 1'b0, kill: 1'b1, addr: addr};
            fetch_open <= 1'b0;
            @(posedge clk);
            fetch_req.kill <= 1'b0;
            repeat (MEM_LATENCY + 4) @(posedge clk);  // Quiet window for a stray ack
        end else begin
            wait_ack(PORT_FETCH, seen);
            fetch_req.req <= 1'b0;
            fetch_open    <= 1'b0;
        end
    endtask

    task automatic mmu_access(input addr_t addr, input logic flush);
        logic seen;
        @(posedge clk);
        mmu_req      <= '{r_req: 1'b1, flush: 1'b0, paddr: addr};
        exp_mmu_data <= shadow[addr[MEM_AW+1:2]];
        mmu_open     <= 1'b1;
        if (flush) begin
            repeat (2) @(posedge clk);  // Walk read holds the data port here
            mmu_req  <= '{r_req: 1'b0, flush: 1'b1, paddr: addr};
            mmu_open <= 1'b0;
            @(posedge clk);
            mmu_req.flush <= 1'b0;
            repeat (MEM_LATENCY + 4) @(posedge clk);
        end else begin
            wait_ack(PORT_MMU, seen);
            mmu_req.r_req <= 1'b0;
            mmu_open      <= 1'b0;
        end
    endtask

    // Waits past the edge so assertion actions of the last ack are counted
    task automatic report_test(input string name, input int start_errs);
        @(negedge clk);
        if (err_cnt == start_errs) begin
            tests_passed++;
            $display("test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", name, err_cnt - start_errs);
        end
    endtask

    initial begin
        int          start;
        logic [31:0] r;
        logic [31:0] wd;
        logic [7:0]  idx8;
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_req    = '0;
        dbus_req     = '0;
        mmu_req      = '0;
        rng_q        = 32'd65;
        dbus_open    = 1'b0;
        fetch_open   = 1'b0;
        mmu_open     = 1'b0;
        prio_fetch   = 1'b0;
        prio_mmu     = 1'b0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        start = err_cnt;
        for (int i = 0; i < N_WORDS; i++) begin
            r            = next_rand();
            idx8         = 8'(i * 32) | {3'b000, r[4:0]};  // Distinct word per slot
            word_addr[i] = {r[31:10], idx8, 2'b00};
            lsu_access(1'b1, word_addr[i], next_rand(), 4'hF);  // Full word defines it
        end
        for (int i = 0; i < N_WORDS; i++) begin
            wd = next_rand();
            r  = next_rand();
            lsu_access(1'b1, word_addr[i], wd, r[3:0]);
        end
        for (int i = 0; i < N_WORDS; i++) lsu_access(1'b0, word_addr[i], '0, '0);
        report_test("lsu write and read-back", start);

        start = err_cnt;
        for (int i = 0; i < N_WORDS; i++) fetch_access(word_addr[(i + 3) % N_WORDS], 1'b0, 0);
        report_test("fetch reads", start);

        start = err_cnt;
        for (int i = 0; i < N_WORDS; i++) mmu_access(word_addr[(i + 5) % N_WORDS], 1'b0);
        report_test("mmu reads", start);

        start = err_cnt;
        for (int i = 0; i < 2; i++) begin
            mmu_access(word_addr[2 * i], 1'b1);
            mmu_access(word_addr[2 * i + 1], 1'b0);
        end
        report_test("mmu flush", start);

        start = err_cnt;
        for (int i = 0; i < 2; i++) begin
            fetch_access(word_addr[2 * i + 4], 1'b1, 0);
            fetch_access(word_addr[2 * i + 5], 1'b0, 0);
        end
        report_test("fetch kill", start);

        // Fetch one edge late, both reach the memory arbiter together
        start      = err_cnt;
        prio_fetch = 1'b1;
        fork
            lsu_access(1'b0, word_addr[1], '0, '0);
            fetch_access(word_addr[6], 1'b0, 1);
        join
        prio_fetch = 1'b0;
        prio_mmu   = 1'b1;
        fork
            lsu_access(1'b0, word_addr[2], '0, '0);
            mmu_access(word_addr[7], 1'b0);
        join
        prio_mmu = 1'b0;
        report_test("priority", start);

        $display("tests ok=%0d failed=%0d, errors=%0d", tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Budget per access is twice a slow contended access
    initial begin
        #(NUM_ACCESSES * 2 * (MEM_LATENCY + 4) * CLK_PERIOD);
        $display("error time=%0t: run did not finish in time, stopped by watchdog", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

/* filelist.f */
hdl/mem_bus_pkg.sv
hdl/mem_port_pkg.sv
hdl/dport_arbiter.sv
hdl/mem_arbiter.sv
hdl/main_mem.sv
hdl/mem_subsys_top.sv
verification/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  # Packages first, the port package uses the bus package types
  - hdl/mem_bus_pkg.sv
  - hdl/mem_port_pkg.sv
  # RTL
  - hdl/dport_arbiter.sv
  - hdl/mem_arbiter.sv
  - hdl/main_mem.sv
  - hdl/mem_subsys_top.sv
  # Testbench
  - target: test
    files:
      - verification/mem_subsys_tb.sv
